//--- Makefile
# Verilator build and run of the AXI line adapter testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_axi_line_adapter -Mdir obj_dir -f list.f
	./obj_dir/Vtb_axi_line_adapter | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/axi_mem_model.sv
// AXI slave memory for the adapter testbench
// random ready/valid stalls, burst length, alignment and last-beat checks
`timescale 1ns/1ps

module axi_mem_model
  import axi_line_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // kind of the request the cache is driving
  input  req_kind_e         kind_i,
  input  logic              aw_valid_i,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic [7:0]        aw_len_i,
  input  logic [ID_W-1:0]   aw_id_i,
  output logic              aw_ready_o,
  input  logic              w_valid_i,
  input  word_t             w_data_i,
  input  strb_t             w_strb_i,
  input  logic              w_last_i,
  output logic              w_ready_o,
  output logic              b_valid_o,
  output logic [ID_W-1:0]   b_id_o,
  input  logic              b_ready_i,
  input  logic              ar_valid_i,
  input  logic [ADDR_W-1:0] ar_addr_i,
  input  logic [7:0]        ar_len_i,
  input  logic [ID_W-1:0]   ar_id_i,
  output logic              ar_ready_o,
  output logic              r_valid_o,
  output word_t             r_data_o,
  output logic [ID_W-1:0]   r_id_o,
  output logic              r_last_o,
  input  logic              r_ready_i,
  output int                errs_o
);

  word_t             mem [int unsigned];
  word_t             wbuf [LINE_BEATS];
  strb_t             wstrb [LINE_BEATS];
  int unsigned       w_cnt;
  logic              aw_got, w_done, b_pending;
  logic [ADDR_W-1:0] wr_addr;
  logic [ID_W-1:0]   wr_id;
  logic              rd_busy;
  logic [ADDR_W-1:0] rd_addr;
  logic [7:0]        rd_len, rd_beat;
  logic [ID_W-1:0]   rd_id;

  // untouched words hold their own byte address
  function automatic word_t fill_word(input int unsigned idx);
    logic [31:0] a;
    a = idx << 3;
    return {~a, a};
  endfunction

  function automatic word_t load(input int unsigned idx);
    if (mem.exists(idx)) begin
      return mem[idx];
    end
    return fill_word(idx);
  endfunction

  function automatic void store(input int unsigned idx, input word_t d, input strb_t s);
    word_t cur;
    cur = load(idx);
    for (int b = 0; b < DATA_W / 8; b++) begin
      if (s[b]) begin
        cur[8*b +: 8] = d[8*b +: 8];
      end
    end
    mem[idx] = cur;
  endfunction

  // one cycle in three is a stall
  function automatic logic stall();
    return ($urandom_range(2) == 0);
  endfunction

  function automatic logic [7:0] expected_len(input req_kind_e k);
    return (k == LINE_REQ) ? 8'd3 : 8'd0;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_id_o     <= '0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_id_o     <= '0;
      r_last_o   <= 1'b0;
      errs_o     = 0;
      w_cnt      = 0;
      aw_got     = 1'b0;
      w_done     = 1'b0;
      b_pending  = 1'b0;
      rd_busy    = 1'b0;
      rd_beat    = '0;
    end else begin
      // --------------------------------------------------
      // write side
      // --------------------------------------------------
      if (aw_valid_i && aw_ready_o) begin
        assert (aw_len_i == expected_len(kind_i)) else begin
          errs_o++;
          $display("memory model: write burst length %0d does not fit the request kind",
                   aw_len_i);
        end
        wr_addr = aw_addr_i;
        wr_id   = aw_id_i;
        aw_got  = 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
        assert (w_last_i == (kind_i == SINGLE_REQ || w_cnt == LINE_BEATS - 1)) else begin
          errs_o++;
          $display("memory model: w_last is %0b on write beat %0d", w_last_i, w_cnt);
        end
        if (w_cnt < LINE_BEATS) begin
          wbuf[w_cnt]  = w_data_i;
          wstrb[w_cnt] = w_strb_i;
        end
        w_cnt++;
        if (w_last_i) begin
          w_done = 1'b1;
        end
      end
      // both address and data are in, commit the burst
      if (aw_got && w_done) begin
        for (int i = 0; i < w_cnt && i < LINE_BEATS; i++) begin
          store((wr_addr >> 3) + i, wbuf[i], wstrb[i]);
        end
        aw_got    = 1'b0;
        w_done    = 1'b0;
        w_cnt     = 0;
        b_pending = 1'b1;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end else if (b_pending && !b_valid_o && !stall()) begin
        b_valid_o <= 1'b1;
        b_id_o    <= wr_id;
        b_pending = 1'b0;
      end
      aw_ready_o <= !aw_got && !b_pending && !stall();
      w_ready_o  <= !w_done && !b_pending && !stall();

      // --------------------------------------------------
      // read side
      // --------------------------------------------------
      if (ar_valid_i && ar_ready_o) begin
        assert (ar_len_i == expected_len(kind_i)) else begin
          errs_o++;
          $display("memory model: read burst length %0d does not fit the request kind",
                   ar_len_i);
        end
        if (kind_i == LINE_REQ) begin
          assert (ar_addr_i[LINE_OFFSET_W-1:0] == '0) else begin
            errs_o++;
            $display("memory model: line read address %h is not line aligned", ar_addr_i);
          end
        end
        rd_busy = 1'b1;
        rd_addr = ar_addr_i;
        rd_len  = ar_len_i;
        rd_id   = ar_id_i;
        rd_beat = '0;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        if (r_last_o) begin
          rd_busy = 1'b0;
        end
        rd_beat = rd_beat + 8'd1;
      end else if (rd_busy && !r_valid_o && !stall()) begin
        r_valid_o <= 1'b1;
        r_data_o  <= load((rd_addr >> 3) + rd_beat);
        r_id_o    <= rd_id;
        r_last_o  <= (rd_beat == rd_len);
      end
      ar_ready_o <= !rd_busy && !stall();
    end
  end

endmodule

//--- bench/tb_axi_line_adapter.sv
// testbench for the AXI line adapter
// stimulus, shadow-memory reference, response checks, watchdog and report
`timescale 1ns/1ps

module tb_axi_line_adapter
  import axi_line_pkg::*;
();

  localparam int unsigned       SEED     = 54661;
  localparam int unsigned       N_LINES  = 8;
  localparam int unsigned       N_RANDOM = 60;
  localparam int unsigned       N_TXN    = N_LINES + 4 + N_RANDOM;
  localparam logic [ADDR_W-1:0] BASE     = 32'h0000_1000;

  typedef struct {
    logic              we;
    req_kind_e         kind;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    line_t             data;
  } exp_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req, we;
  req_kind_e         kind;
  logic [ADDR_W-1:0] addr;
  logic [1:0]        size;
  logic [ID_W-1:0]   id;
  line_t             wdata, rdata;
  line_strb_t        be;
  logic              gnt, valid, crit_valid;
  logic [ID_W-1:0]   rsp_id;
  word_t             crit_word;
  logic              aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic              ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic [ADDR_W-1:0] aw_addr, ar_addr;
  logic [7:0]        aw_len, ar_len;
  logic [2:0]        aw_size, ar_size;
  logic [1:0]        aw_burst, ar_burst;
  logic [ID_W-1:0]   aw_id, ar_id, b_id, r_id;
  word_t             w_data, r_data;
  strb_t             w_strb;

  word_t shadow [int unsigned];
  exp_t  exp_q [$];
  exp_t  cur;
  int    err_cnt, proto_errs, valid_cnt, gnt_in_txn, cw_cnt;
  logic  last_beat_q;

  always #5 clk = ~clk;

  axi_line_adapter i_axi_line_adapter (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .we_i (we), .kind_i (kind), .addr_i (addr), .size_i (size),
    .id_i (id), .wdata_i (wdata), .be_i (be),
    .gnt_o (gnt), .valid_o (valid), .rdata_o (rdata), .id_o (rsp_id),
    .critical_word_o (crit_word), .critical_word_valid_o (crit_valid),
    .aw_valid_o (aw_valid), .aw_addr_o (aw_addr), .aw_len_o (aw_len), .aw_size_o (aw_size),
    .aw_burst_o (aw_burst), .aw_id_o (aw_id), .aw_ready_i (aw_ready),
    .w_valid_o (w_valid), .w_data_o (w_data), .w_strb_o (w_strb), .w_last_o (w_last),
    .w_ready_i (w_ready), .b_valid_i (b_valid), .b_id_i (b_id), .b_ready_o (b_ready),
    .ar_valid_o (ar_valid), .ar_addr_o (ar_addr), .ar_len_o (ar_len), .ar_size_o (ar_size),
    .ar_burst_o (ar_burst), .ar_id_o (ar_id), .ar_ready_i (ar_ready),
    .r_valid_i (r_valid), .r_data_i (r_data), .r_id_i (r_id), .r_last_i (r_last),
    .r_ready_o (r_ready)
  );

  axi_mem_model i_axi_mem_model (
    .clk_i (clk), .rst_ni (rst_n), .kind_i (kind),
    .aw_valid_i (aw_valid), .aw_addr_i (aw_addr), .aw_len_i (aw_len), .aw_id_i (aw_id),
    .aw_ready_o (aw_ready), .w_valid_i (w_valid), .w_data_i (w_data), .w_strb_i (w_strb),
    .w_last_i (w_last), .w_ready_o (w_ready), .b_valid_o (b_valid), .b_id_o (b_id),
    .b_ready_i (b_ready), .ar_valid_i (ar_valid), .ar_addr_i (ar_addr), .ar_len_i (ar_len),
    .ar_id_i (ar_id), .ar_ready_o (ar_ready), .r_valid_o (r_valid), .r_data_o (r_data),
    .r_id_o (r_id), .r_last_o (r_last), .r_ready_i (r_ready), .errs_o (proto_errs)
  );

  // --------------------------------------------------
  // reference model and stimulus
  // --------------------------------------------------
  // merges a write into the shadow copy by byte enables and returns what a read sees
  function automatic line_t reference(input logic w, input req_kind_e k,
                                      input logic [ADDR_W-1:0] a,
                                      input line_t d, input line_strb_t s);
    line_t       res;
    word_t       word;
    int unsigned base;
    int unsigned beats;
    res   = '0;
    beats = (k == LINE_REQ) ? 4 : 1;
    base  = (k == LINE_REQ) ? (a >> 5) * 4 : a >> 3;
    for (int i = 0; i < beats; i++) begin
      word = shadow.exists(base + i) ? shadow[base + i] : '0;
      if (w) begin
        for (int b = 0; b < 8; b++) begin
          if (s[i][b]) begin
            word[8*b +: 8] = d[i][8*b +: 8];
          end
        end
        shadow[base + i] = word;
      end
      res[i] = word;
    end
    return res;
  endfunction

  function automatic line_t random_line();
    line_t res;
    for (int i = 0; i < LINE_BEATS; i++) begin
      res[i] = {$urandom, $urandom};
    end
    return res;
  endfunction

  // holds the request until the grant, then waits for the response
  task automatic issue(input logic w, input req_kind_e k, input logic [ADDR_W-1:0] a,
                       input line_t d, input line_strb_t s);
    exp_t e;
    e.we   = w;
    e.kind = k;
    e.addr = a;
    e.id   = ID_W'($urandom);
    e.data = reference(w, k, a, d, s);
    exp_q.push_back(e);
    req   <= 1'b1;
    we    <= w;
    kind  <= k;
    addr  <= a;
    id    <= e.id;
    wdata <= d;
    be    <= s;
    do @(posedge clk); while (!gnt);
    req <= 1'b0;
    do @(posedge clk); while (!valid);
  endtask

  initial begin
    logic              w;
    req_kind_e         k;
    logic [ADDR_W-1:0] a;
    void'($urandom(SEED));
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    kind  = SINGLE_REQ;
    addr  = '0;
    size  = 2'd3;
    id    = '0;
    wdata = '0;
    be    = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!gnt && !valid && !crit_valid && !aw_valid && !w_valid && !b_ready &&
            !ar_valid && !r_ready) else begin
      err_cnt++;
      $display("ERR %0t: outputs not idle after reset", $time);
    end
    // whole lines first so that every later access hits known data
    for (int l = 0; l < N_LINES; l++) begin
      issue(1'b1, LINE_REQ, BASE + ADDR_W'(l * 32), random_line(), '1);
    end
    // partial single write, then read back the merged word
    issue(1'b1, SINGLE_REQ, BASE + 32'h48, random_line(), line_strb_t'(8'h5a));
    issue(1'b0, SINGLE_REQ, BASE + 32'h48, '0, '0);
    // line read starting from inside the line
    issue(1'b1, LINE_REQ, BASE + 32'h60, random_line(), '1);
    issue(1'b0, LINE_REQ, BASE + 32'h78, '0, '0);
    for (int n = 0; n < N_RANDOM; n++) begin
      w = $urandom_range(1);
      k = req_kind_e'($urandom_range(1));
      a = BASE + ADDR_W'($urandom_range(N_LINES - 1) * 32);
      if (!(w && k == LINE_REQ)) begin
        a = a + ADDR_W'($urandom_range(3) * 8);
      end
      issue(w, k, a, random_line(), line_strb_t'($urandom));
    end
    repeat (5) @(posedge clk);
    assert (valid_cnt == N_TXN) else begin
      err_cnt++;
      $display("ERR %0t: %0d responses for %0d requests", $time, valid_cnt, N_TXN);
    end
    $display("errors: %0d compare, %0d protocol, %0d of %0d requests answered",
             err_cnt, proto_errs, valid_cnt, N_TXN);
    if (err_cnt == 0 && proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // --------------------------------------------------
  // response checks
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      if (gnt) begin
        gnt_in_txn++;
      end
      // every burst is incrementing with 8-byte beats
      if (aw_valid && aw_ready) begin
        assert (aw_burst == 2'b01 && aw_size == 3'd3) else begin
          err_cnt++;
          $display("ERR %0t: aw burst %b size %0d, expected 01 and 3", $time,
                   aw_burst, aw_size);
        end
      end
      if (ar_valid && ar_ready) begin
        assert (ar_burst == 2'b01 && ar_size == 3'd3) else begin
          err_cnt++;
          $display("ERR %0t: ar burst %b size %0d, expected 01 and 3", $time,
                   ar_burst, ar_size);
        end
      end
      if (crit_valid && exp_q.size() > 0) begin
        cw_cnt++;
        assert (crit_word == exp_q[0].data[exp_q[0].addr[4:3]]) else begin
          err_cnt++;
          $display("ERR %0t: critical word %h, expected %h", $time, crit_word,
                   exp_q[0].data[exp_q[0].addr[4:3]]);
        end
      end
      if (last_beat_q) begin
        assert (valid) else begin
          err_cnt++;
          $display("ERR %0t: no valid_o one cycle after the last read beat", $time);
        end
      end
      if (valid) begin
        assert (exp_q.size() > 0) else begin
          err_cnt++;
          $display("valid_o pulsed while no request was outstanding");
        end
      end
      if (valid && exp_q.size() > 0) begin
        cur = exp_q.pop_front();
        valid_cnt++;
        assert (rsp_id == cur.id) else begin
          err_cnt++;
          $display("ERR %0t: id_o %h, expected %h", $time, rsp_id, cur.id);
        end
        assert (gnt_in_txn == 1) else begin
          err_cnt++;
          $display("ERR %0t: %0d grants for request id %h", $time, gnt_in_txn, cur.id);
        end
        if (!cur.we) begin
          assert (last_beat_q) else begin
            err_cnt++;
            $display("ERR %0t: read valid_o without a last beat the cycle before", $time);
          end
          if (cur.kind == LINE_REQ) begin
            assert (rdata == cur.data && cw_cnt == 1) else begin
              err_cnt++;
              $display("ERR %0t: line %h with %0d critical words, expected %h", $time,
                       rdata, cw_cnt, cur.data);
            end
          end else begin
            assert (rdata[0] == cur.data[0] && cw_cnt == 0) else begin
              err_cnt++;
              $display("ERR %0t: word %h with %0d critical words, expected %h", $time,
                       rdata[0], cw_cnt, cur.data[0]);
            end
          end
        end
        gnt_in_txn = 0;
        cw_cnt     = 0;
      end
      last_beat_q = r_valid & r_ready & r_last;
    end else begin
      last_beat_q = 1'b0;
    end
  end

  // watchdog sized for the slowest stalled transfer
  initial begin
    repeat (N_TXN * 200) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", N_TXN * 200);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- hdl/axi_line_adapter.sv
// cache-side request/grant port to AXI4 adapter, top level
// address channel fields and the instances of FSM, write and read paths
`timescale 1ns/1ps

module axi_line_adapter
  import axi_line_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  // cache request
  input  logic              req_i,
  input  logic              we_i,
  input  req_kind_e         kind_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [1:0]        size_i,
  input  logic [ID_W-1:0]   id_i,
  input  line_t             wdata_i,
  input  line_strb_t        be_i,
  // cache response
  output logic              gnt_o,
  output logic              valid_o,
  output line_t             rdata_o,
  output logic [ID_W-1:0]   id_o,
  output word_t             critical_word_o,
  output logic              critical_word_valid_o,
  // write address channel
  output logic              aw_valid_o,
  output logic [ADDR_W-1:0] aw_addr_o,
  output logic [7:0]        aw_len_o,
  output logic [2:0]        aw_size_o,
  output logic [1:0]        aw_burst_o,
  output logic [ID_W-1:0]   aw_id_o,
  input  logic              aw_ready_i,
  // write data channel
  output logic              w_valid_o,
  output word_t             w_data_o,
  output strb_t             w_strb_o,
  output logic              w_last_o,
  input  logic              w_ready_i,
  // write response channel
  input  logic              b_valid_i,
  input  logic [ID_W-1:0]   b_id_i,
  output logic              b_ready_o,
  // read address channel
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  output logic [7:0]        ar_len_o,
  output logic [2:0]        ar_size_o,
  output logic [1:0]        ar_burst_o,
  output logic [ID_W-1:0]   ar_id_o,
  input  logic              ar_ready_i,
  // read data channel
  input  logic              r_valid_i,
  input  word_t             r_data_i,
  input  logic [ID_W-1:0]   r_id_i,
  input  logic              r_last_i,
  output logic              r_ready_o
);

  logic            w_fire, w_last, ar_fire, rd_done;
  logic [ID_W-1:0] rd_id;
  logic [7:0]      axi_len;

  // --------------------------------------------------
  // address channel fields
  // --------------------------------------------------
  assign axi_len = (kind_i == LINE_REQ) ? LINE_LEN : 8'd0;

  assign aw_addr_o  = addr_i;
  assign aw_len_o   = axi_len;
  assign aw_size_o  = {1'b0, size_i};
  assign aw_burst_o = BURST_INCR;
  assign aw_id_o    = id_i;

  // line reads start at the line base
  assign ar_addr_o  = (kind_i == LINE_REQ) ?
                      {addr_i[ADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}} : addr_i;
  assign ar_len_o   = axi_len;
  assign ar_size_o  = {1'b0, size_i};
  assign ar_burst_o = BURST_INCR;
  assign ar_id_o    = id_i;

  assign w_last_o = w_last;

  axi_line_ctrl i_axi_line_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .we_i       (we_i),
    .kind_i     (kind_i),
    .gnt_o      (gnt_o),
    .valid_o    (valid_o),
    .id_o       (id_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .b_valid_i  (b_valid_i),
    .b_id_i     (b_id_i),
    .b_ready_o  (b_ready_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .w_fire_o   (w_fire),
    .ar_fire_o  (ar_fire),
    .w_last_i   (w_last),
    .rd_done_i  (rd_done),
    .rd_id_i    (rd_id)
  );

  axi_write_beats i_axi_write_beats (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .kind_i   (kind_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .w_fire_i (w_fire),
    .w_data_o (w_data_o),
    .w_strb_o (w_strb_o),
    .w_last_o (w_last)
  );

  axi_read_assembler i_axi_read_assembler (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .kind_i                (kind_i),
    .addr_i                (addr_i),
    .ar_fire_i             (ar_fire),
    .r_valid_i             (r_valid_i),
    .r_ready_i             (r_ready_o),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i),
    .rdata_o               (rdata_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .rd_done_o             (rd_done),
    .rd_id_o               (rd_id)
  );

endmodule

//--- hdl/axi_line_ctrl.sv
// transaction FSM of the AXI line adapter
// drives grant, completion pulse and the AXI valid/ready handshakes
`timescale 1ns/1ps

module axi_line_ctrl
  import axi_line_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  // request side
  input  logic            req_i,
  input  logic            we_i,
  input  req_kind_e       kind_i,
  // response side
  output logic            gnt_o,
  output logic            valid_o,
  output logic [ID_W-1:0] id_o,
  // AXI handshakes
  output logic            aw_valid_o,
  input  logic            aw_ready_i,
  output logic            w_valid_o,
  input  logic            w_ready_i,
  input  logic            b_valid_i,
  input  logic [ID_W-1:0] b_id_i,
  output logic            b_ready_o,
  output logic            ar_valid_o,
  input  logic            ar_ready_i,
  input  logic            r_valid_i,
  output logic            r_ready_o,
  // datapath
  output logic            w_fire_o,
  output logic            ar_fire_o,
  input  logic            w_last_i,
  input  logic            rd_done_i,
  input  logic [ID_W-1:0] rd_id_i
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW,
    WAIT_W,
    WAIT_AW_W,
    WAIT_B,
    WAIT_R,
    COMPLETE_READ
  } state_e;

  state_e state_q, state_d;

  // write progress within this cycle
  logic aw_hs, wl_hs;
  // address / last data beat already accepted or accepted now
  logic aw_ok, wl_ok;

  // --------------------------------------------------
  // next state and handshakes
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    b_ready_o  = 1'b0;
    r_ready_o  = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (we_i) begin
            aw_valid_o = 1'b1;
            w_valid_o  = 1'b1;
          end else begin
            ar_valid_o = 1'b1;
            gnt_o      = ar_ready_i;
            if (ar_ready_i) begin
              state_d = WAIT_R;
            end
          end
        end
      end
      // data done, address still pending
      WAIT_AW: aw_valid_o = 1'b1;
      // address done, data beats still pending
      WAIT_W: w_valid_o = 1'b1;
      WAIT_AW_W: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
      end
      WAIT_B: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          valid_o = 1'b1;
          state_d = IDLE;
        end
      end
      WAIT_R: begin
        r_ready_o = 1'b1;
        if (rd_done_i) begin
          state_d = COMPLETE_READ;
        end
      end
      COMPLETE_READ: begin
        valid_o = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // a single write carries its only beat, which is also the last
    aw_hs = aw_valid_o & aw_ready_i;
    wl_hs = w_valid_o & w_ready_i & ((kind_i == SINGLE_REQ) | w_last_i);
    aw_ok = aw_hs | (state_q == WAIT_W);
    wl_ok = wl_hs | (state_q == WAIT_AW);

    if (aw_valid_o || w_valid_o) begin
      if (aw_ok && wl_ok) begin
        gnt_o   = 1'b1;
        state_d = WAIT_B;
      end else if (aw_ok) begin
        state_d = WAIT_W;
      end else if (wl_ok) begin
        state_d = WAIT_AW;
      end else if (w_valid_o && w_ready_i) begin
        // first beats of a line went out before the address
        state_d = WAIT_AW_W;
      end
    end
  end

  assign w_fire_o  = w_valid_o & w_ready_i;
  assign ar_fire_o = ar_valid_o & ar_ready_i;

  // write completion reports the b id, reads the captured r id
  assign id_o = (state_q == WAIT_B) ? b_id_i : rd_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- hdl/axi_line_pkg.sv
// widths, beat-index and cache-line types for the AXI line adapter
// request kinds and AXI burst encodings
package axi_line_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned DATA_W        = 64;
  localparam int unsigned LINE_BEATS    = 4;
  localparam int unsigned BEAT_IDX_W    = 2;
  localparam int unsigned LINE_OFFSET_W = 5;
  localparam int unsigned WORD_OFFSET_W = 3;
  localparam int unsigned ID_W          = 4;

  // --------------------------------------------------
  // AXI encodings
  // --------------------------------------------------
  localparam logic [1:0] BURST_INCR = 2'b01;
  // len field of a full cache-line burst
  localparam logic [7:0] LINE_LEN   = 8'(LINE_BEATS - 1);

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [DATA_W/8-1:0]   strb_t;
  typedef word_t [LINE_BEATS-1:0] line_t;
  typedef strb_t [LINE_BEATS-1:0] line_strb_t;
  typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

  // single word or whole cache line
  typedef enum logic {
    SINGLE_REQ = 1'b0,
    LINE_REQ   = 1'b1
  } req_kind_e;

endpackage

//--- hdl/axi_read_assembler.sv
// read-beat assembler: beat counter, cache-line register,
// critical-word flag and capture of the read id
`timescale 1ns/1ps

module axi_read_assembler
  import axi_line_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  req_kind_e         kind_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              ar_fire_i,
  input  logic              r_valid_i,
  input  logic              r_ready_i,
  input  word_t             r_data_i,
  input  logic [ID_W-1:0]   r_id_i,
  input  logic              r_last_i,
  output line_t             rdata_o,
  output word_t             critical_word_o,
  output logic              critical_word_valid_o,
  output logic              rd_done_o,
  output logic [ID_W-1:0]   rd_id_o
);

  beat_idx_t       cnt_q;
  // word the cache asked for
  beat_idx_t       offset_q;
  logic            is_line_q;
  line_t           line_q;
  logic [ID_W-1:0] id_q;
  logic            r_fire;
  beat_idx_t       index;

  assign r_fire = r_valid_i & r_ready_i;
  assign index  = is_line_q ? cnt_q : '0;

  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_fire & is_line_q & (index == offset_q);
  assign rd_done_o             = r_fire & r_last_i;
  assign rdata_o               = line_q;
  assign rd_id_o               = id_q;

  // --------------------------------------------------
  // burst tracking
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      offset_q  <= '0;
      is_line_q <= 1'b0;
    end else if (ar_fire_i) begin
      cnt_q     <= '0;
      offset_q  <= addr_i[WORD_OFFSET_W +: BEAT_IDX_W];
      is_line_q <= (kind_i == LINE_REQ);
    end else if (r_fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // line data and id
  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      line_q[index] <= r_data_i;
      if (r_last_i) begin
        id_q <= r_id_i;
      end
    end
  end

endmodule

//--- hdl/axi_write_beats.sv
// write-beat sequencer
// picks data and strobe of the current beat and flags the last one
`timescale 1ns/1ps

module axi_write_beats
  import axi_line_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  req_kind_e  kind_i,
  input  line_t      wdata_i,
  input  line_strb_t be_i,
  input  logic       w_fire_i,
  output word_t      w_data_o,
  output strb_t      w_strb_o,
  output logic       w_last_o
);

  beat_idx_t cnt_q;

  // single writes always stay on beat 0
  assign w_last_o = (kind_i == SINGLE_REQ) ||
                    (cnt_q == beat_idx_t'(LINE_BEATS - 1));

  assign w_data_o = wdata_i[cnt_q];
  assign w_strb_o = be_i[cnt_q];

  // --------------------------------------------------
  // beat counter
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (w_fire_i) begin
      if (w_last_o) begin
        // ready for the next burst
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

//--- list.f
hdl/axi_line_pkg.sv
hdl/axi_line_ctrl.sv
hdl/axi_write_beats.sv
hdl/axi_read_assembler.sv
hdl/axi_line_adapter.sv
bench/axi_mem_model.sv
bench/tb_axi_line_adapter.sv
